/* hdl/board_pkg.sv */
`default_nettype none

package board_pkg;

    //////////////////////////////
    // Board resources
    //////////////////////////////

    // Slide switches on the board
    localparam int unsigned NUM_I = 4;

    // User LEDs driven by the design
    localparam int unsigned NUM_O = 4;

    // Header pins in use, counted from ck_io[0]
    localparam int unsigned NUM_IO = 5;

    // Full width of the shield header bus
    localparam int unsigned CK_IO_WIDTH = 42;

    //////////////////////////////
    // Reset
    //////////////////////////////

    // Flops between the reset button and rst_n
    localparam int unsigned RST_SYNC_STAGES = 4;

endpackage

`default_nettype wire

/* hdl/gpio_pkg.sv */
`default_nettype none

package gpio_pkg;

    //////////////////////////////
    // Input capture
    //////////////////////////////

    // Flops per input synchronizer
    localparam int unsigned IN_SYNC_STAGES = 2;

    // Bits per rising-edge counter, wraps at the top
    localparam int unsigned COUNT_WIDTH = 8;

    //////////////////////////////
    // Switch word layout
    //////////////////////////////

    // High selects count view, low selects direct view
    localparam int unsigned SW_VIEW_BIT = 3;

    // Pin select field in the low switches
    localparam int unsigned SW_SEL_WIDTH = 3;

    //////////////////////////////
    // Output pattern
    //////////////////////////////

    // Clock cycles spent on each walking-one position
    localparam int unsigned STEP_CYCLES_DEFAULT = 16;

endpackage

`default_nettype wire

/* hdl/reset_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_sync #(
    parameter int unsigned STAGES = board_pkg::RST_SYNC_STAGES
) (
    input  logic clk,
    // Active high, may toggle at any time
    input  logic arst,
    output logic rst_n
);

    // Shift chain, all zero while in reset
    logic [STAGES-1:0] sync_q;

    //////////////////////////////
    // Synchronizer chain
    //////////////////////////////

    // Assert without a clock
    // Release walks a one through the chain
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], 1'b1};
        end
    end

    // Last stage is the clean reset
    assign rst_n = sync_q[STAGES-1];

endmodule

`default_nettype wire

/* hdl/pin_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module pin_monitor #(
    parameter int unsigned NUM_IO      = board_pkg::NUM_IO,
    parameter int unsigned COUNT_WIDTH = gpio_pkg::COUNT_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Raw header levels, asynchronous to clk
    input  logic [NUM_IO-1:0]             p_i,
    output logic [NUM_IO-1:0]             pin_level,
    // Pin 0 counter in the low bits
    output logic [NUM_IO*COUNT_WIDTH-1:0] edge_count
);

    import gpio_pkg::*;

    // Synchronizer stages, index 0 samples the pins
    logic [IN_SYNC_STAGES-1:0][NUM_IO-1:0] sync_q;
    // Level one cycle behind pin_level
    logic [NUM_IO-1:0]                     level_q;
    // One bit per pin that just went high
    logic [NUM_IO-1:0]                     rise;
    // One counter per pin
    logic [NUM_IO-1:0][COUNT_WIDTH-1:0]    count_q;

    //////////////////////////////
    // Input synchronizers
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[IN_SYNC_STAGES-2:0], p_i};
        end
    end

    assign pin_level = sync_q[IN_SYNC_STAGES-1];

    //////////////////////////////
    // Rising edge detect
    //////////////////////////////

    // Reset low so a pin held high after reset counts once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= '0;
        end else begin
            level_q <= pin_level;
        end
    end

    assign rise = pin_level & ~level_q;

    //////////////////////////////
    // Edge counters
    //////////////////////////////

    // Independent per pin
    // Several pins may step in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            for (int i = 0; i < NUM_IO; i++) begin
                // Natural wrap from all ones to zero
                if (rise[i]) begin
                    count_q[i] <= count_q[i] + COUNT_WIDTH'(1);
                end
            end
        end
    end

    // Flatten, pin 0 lowest
    assign edge_count = count_q;

endmodule

`default_nettype wire

/* hdl/led_view.sv */
`timescale 1ns/1ps
`default_nettype none

module led_view #(
    parameter int unsigned NUM_I       = board_pkg::NUM_I,
    parameter int unsigned NUM_O       = board_pkg::NUM_O,
    parameter int unsigned NUM_IO      = board_pkg::NUM_IO,
    parameter int unsigned COUNT_WIDTH = gpio_pkg::COUNT_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Switches, asynchronous to clk
    input  logic [NUM_I-1:0]              gpi,
    input  logic [NUM_IO-1:0]             pin_level,
    input  logic [NUM_IO*COUNT_WIDTH-1:0] edge_count,
    output logic [NUM_O-1:0]              gpo
);

    import gpio_pkg::*;

    // Switch synchronizer stages
    logic [IN_SYNC_STAGES-1:0][NUM_I-1:0] sw_q;
    // Synchronized switch word
    logic [NUM_I-1:0]                     sw_sync;
    // Pin select field
    logic [SW_SEL_WIDTH-1:0]              sel;
    // Counters viewed per pin
    logic [NUM_IO-1:0][COUNT_WIDTH-1:0]   count_arr;
    // Next LED value
    logic [NUM_O-1:0]                     view_d;

    //////////////////////////////
    // Switch synchronizer
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sw_q <= '0;
        end else begin
            sw_q <= {sw_q[IN_SYNC_STAGES-2:0], gpi};
        end
    end

    assign sw_sync   = sw_q[IN_SYNC_STAGES-1];
    assign sel       = sw_sync[SW_SEL_WIDTH-1:0];
    assign count_arr = edge_count;

    //////////////////////////////
    // View select
    //////////////////////////////

    always_comb begin
        view_d = '0;
        if (sw_sync[SW_VIEW_BIT]) begin
            // Count view, low bits of the chosen counter
            // Selects past the last pin stay zero
            if (sel < NUM_IO) begin
                view_d = count_arr[sel][NUM_O-1:0];
            end
        end else begin
            // Direct view of the low pins
            view_d = pin_level[NUM_O-1:0];
        end
    end

    // Registered LED drive
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpo <= '0;
        end else begin
            gpo <= view_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/pattern_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_gen #(
    parameter int unsigned NUM_IO      = board_pkg::NUM_IO,
    parameter int unsigned STEP_CYCLES = gpio_pkg::STEP_CYCLES_DEFAULT
) (
    input  logic              clk,
    input  logic              rst_n,
    // One-hot header drive
    output logic [NUM_IO-1:0] p_o
);

    // Step counter width, at least one bit
    localparam int unsigned STEP_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

    // Cycles spent on the current position
    logic [STEP_W-1:0] step_q;
    // Last cycle of a step
    logic              step_done;
    // Walking-one register
    logic [NUM_IO-1:0] onehot_q;

    //////////////////////////////
    // Step timer
    //////////////////////////////

    assign step_done = (step_q == STEP_W'(STEP_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_q <= '0;
        end else if (step_done) begin
            step_q <= '0;
        end else begin
            step_q <= step_q + STEP_W'(1);
        end
    end

    //////////////////////////////
    // Walking one
    //////////////////////////////

    // Starts on pin 0, moves up, top pin wraps to pin 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            onehot_q <= NUM_IO'(1);
        end else if (step_done) begin
            onehot_q <= {onehot_q[NUM_IO-2:0], onehot_q[NUM_IO-1]};
        end
    end

    assign p_o = onehot_q;

endmodule

`default_nettype wire

/* hdl/synthesis_optimization_top.sv */
`timescale 1ns/1ps
`default_nettype none

module synthesis_optimization_top #(
    parameter int unsigned NUM_I       = board_pkg::NUM_I,
    parameter int unsigned NUM_O       = board_pkg::NUM_O,
    parameter int unsigned NUM_IO      = board_pkg::NUM_IO,
    parameter int unsigned STEP_CYCLES = gpio_pkg::STEP_CYCLES_DEFAULT
) (
    input  logic              clk,
    input  logic              rst_n,
    // Switches and LEDs
    input  logic [NUM_I-1:0]  gpi,
    output logic [NUM_O-1:0]  gpo,
    // Header pins, read and drive sides
    input  logic [NUM_IO-1:0] p_i,
    output logic [NUM_IO-1:0] p_o
);

    import gpio_pkg::*;

    // Monitor to LED view
    logic [NUM_IO-1:0]             pin_level;
    logic [NUM_IO*COUNT_WIDTH-1:0] edge_count;

    //////////////////////////////
    // Input side
    //////////////////////////////

    pin_monitor #(
        .NUM_IO      (NUM_IO),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_pin_monitor (
        .clk        (clk),
        .rst_n      (rst_n),
        .p_i        (p_i),
        .pin_level  (pin_level),
        .edge_count (edge_count)
    );

    //////////////////////////////
    // LED side
    //////////////////////////////

    led_view #(
        .NUM_I       (NUM_I),
        .NUM_O       (NUM_O),
        .NUM_IO      (NUM_IO),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_led_view (
        .clk        (clk),
        .rst_n      (rst_n),
        .gpi        (gpi),
        .pin_level  (pin_level),
        .edge_count (edge_count),
        .gpo        (gpo)
    );

    //////////////////////////////
    // Output side
    //////////////////////////////

    // Free running, gated at the board pins
    pattern_gen #(
        .NUM_IO      (NUM_IO),
        .STEP_CYCLES (STEP_CYCLES)
    ) u_pattern_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .p_o   (p_o)
    );

endmodule

`default_nettype wire

/* hdl/arty_a7_100.sv */
`timescale 1ns/1ps
`default_nettype none

module arty_a7_100 #(
    parameter int unsigned NUM_I       = board_pkg::NUM_I,
    parameter int unsigned NUM_O       = board_pkg::NUM_O,
    parameter int unsigned NUM_IO      = board_pkg::NUM_IO,
    parameter int unsigned STEP_CYCLES = gpio_pkg::STEP_CYCLES_DEFAULT
) (
    // 100 MHz board oscillator
    input  logic                                clk100mhz,
    input  logic [NUM_I-1:0]                    sw,
    // btn[0] resets, btn[1] enables the header drive
    input  logic [3:0]                          btn,
    output logic [NUM_O-1:0]                    led,
    // Shield header, shared in and out
    inout  wire  [board_pkg::CK_IO_WIDTH-1:0]   ck_io
);

    import board_pkg::*;

    logic                   clk;
    logic                   rst_n;
    // Header read and drive sides
    logic [NUM_IO-1:0]      ck_i;
    logic [CK_IO_WIDTH-1:0] ck_o;

    //////////////////////////////
    // Clock and reset
    //////////////////////////////

    assign clk = clk100mhz;

    // Button press resets at once
    // Release lands on a clock edge
    reset_sync #(
        .STAGES (RST_SYNC_STAGES)
    ) u_reset_sync (
        .clk   (clk),
        .arst  (btn[0]),
        .rst_n (rst_n)
    );

    //////////////////////////////
    // Header pins
    //////////////////////////////

    // Always read back, also while driving
    assign ck_i = ck_io[NUM_IO-1:0];

    // Unused header bits held low when driven
    assign ck_o[CK_IO_WIDTH-1:NUM_IO] = '0;

    // Drive only while btn[1] is held
    assign ck_io = btn[1] ? ck_o : 'z;

    //////////////////////////////
    // GPIO subsystem
    //////////////////////////////

    synthesis_optimization_top #(
        .NUM_I       (NUM_I),
        .NUM_O       (NUM_O),
        .NUM_IO      (NUM_IO),
        .STEP_CYCLES (STEP_CYCLES)
    ) u_top (
        .clk   (clk),
        .rst_n (rst_n),
        .gpi   (sw),
        .gpo   (led),
        .p_i   (ck_i),
        .p_o   (ck_o[NUM_IO-1:0])
    );

endmodule

`default_nettype wire

/* dv/tb_arty_a7_100.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_arty_a7_100;

    import board_pkg::*;
    import gpio_pkg::*;

    // Shorter pattern step for simulation
    localparam int STEP_TB = 8;

    logic                   clk;
    logic [NUM_I-1:0]       sw;
    logic [3:0]             btn;
    logic [NUM_O-1:0]       led;
    wire  [CK_IO_WIDTH-1:0] ck_io;
    // Testbench side of the header
    logic [NUM_IO-1:0]      pin_drv;
    // Expected edge count per pin
    logic [COUNT_WIDTH-1:0] exp_count [NUM_IO];
    int                     checks;
    int                     errors;
    int                     timeouts;

    // Pins released while the DUT drives them
    assign ck_io = btn[1] ? 'z : CK_IO_WIDTH'(pin_drv);

    arty_a7_100 #(
        .STEP_CYCLES (STEP_TB)
    ) u_dut (
        .clk100mhz (clk),
        .sw        (sw),
        .btn       (btn),
        .led       (led),
        .ck_io     (ck_io)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Two cycles of btn[0], then room for the synchronizer
    task automatic apply_reset();
        @(negedge clk);
        btn[0] = 1'b1;
        wait_cycles(2);
        btn[0] = 1'b0;
        wait_cycles(RST_SYNC_STAGES + 1);
        for (int p = 0; p < NUM_IO; p++) begin
            exp_count[p] = '0;
        end
    endtask

    // Switch 3 picks the view, low switches the pin
    task automatic set_view(input logic count_view, input int sel);
        @(negedge clk);
        sw[SW_VIEW_BIT] = count_view;
        sw[SW_SEL_WIDTH-1:0] = SW_SEL_WIDTH'(sel);
        wait_cycles(10);
    endtask

    // Pulses 3 cycles high and 3 low
    task automatic pulse_pin(input int pin, input int count);
        @(negedge clk);
        repeat (count) begin
            pin_drv[pin] = 1'b1;
            wait_cycles(3);
            pin_drv[pin] = 1'b0;
            wait_cycles(3);
            exp_count[pin] = exp_count[pin] + 1'b1;
        end
    endtask

    // Bounded wait for the header pattern to move
    task automatic wait_pattern_change(input logic [NUM_IO-1:0] prev,
                                       output logic [NUM_IO-1:0] cur);
        int n;
        n = 0;
        cur = prev;
        while (cur == prev && n < 2 * STEP_TB + 4) begin
            @(negedge clk);
            cur = ck_io[NUM_IO-1:0];
            n++;
        end
        if (cur == prev) begin
            timeouts++;
            $display("timeout at %0d ns: header pattern did not advance in %0d cycles", $time, n);
        end
    endtask

    task automatic check_led(input logic [NUM_O-1:0] got, input logic [NUM_O-1:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s, led %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pins(input logic [NUM_IO-1:0] got, input logic [NUM_IO-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s, pins %b expected %b", $time, what, got, exp);
        end
    endtask

    // Whole shield header, unused bits included
    task automatic check_header(input logic [CK_IO_WIDTH-1:0] got,
                                input logic [CK_IO_WIDTH-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s, header %h expected %h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset_state();
        set_view(1'b0, 0);
        check_led(led, '0, "direct view after reset");
        for (int s = 0; s < 2 ** SW_SEL_WIDTH; s++) begin
            set_view(1'b1, s);
            check_led(led, '0, "count after reset");
        end
    endtask

    task automatic test_direct_view();
        logic [NUM_IO-1:0] value;
        set_view(1'b0, 0);
        repeat (12) begin
            value = NUM_IO'($urandom);
            pin_drv = value;
            wait_cycles(10);
            check_led(led, value[NUM_O-1:0], "direct view");
        end
        pin_drv = '0;
    endtask

    task automatic test_edge_count();
        apply_reset();
        for (int p = 0; p < NUM_IO; p++) begin
            pulse_pin(p, $urandom_range(20, 0));
        end
        for (int p = 0; p < NUM_IO; p++) begin
            set_view(1'b1, p);
            check_led(led, exp_count[p][NUM_O-1:0], "edge count");
        end
    endtask

    // 260 edges wrap the 8 bit counter past 255
    task automatic test_wrap_and_range();
        apply_reset();
        pulse_pin(0, 260);
        set_view(1'b1, 0);
        check_led(led, exp_count[0][NUM_O-1:0], "wrapped count");
        for (int s = NUM_IO; s < 2 ** SW_SEL_WIDTH; s++) begin
            set_view(1'b1, s);
            check_led(led, '0, "select past last pin");
        end
    endtask

    task automatic test_walking_one();
        int                pos;
        logic [NUM_IO-1:0] cur;
        @(negedge clk);
        btn[1] = 1'b1;
        // Restart so the walk begins on pin 0
        apply_reset();
        pos = 0;
        // Only pin 0 high, unused bits low
        check_header(ck_io, CK_IO_WIDTH'(1), "header drive after reset");
        // Enough steps to wrap twice
        repeat (2 * NUM_IO + 1) begin
            wait_pattern_change(NUM_IO'(1) << pos, cur);
            pos = (pos + 1) % NUM_IO;
            check_pins(cur, NUM_IO'(1) << pos, "walking one step");
        end
    endtask

    task automatic test_reset_mid_run();
        logic [NUM_IO-1:0] cur;
        @(negedge clk);
        btn[1] = 1'b0;
        pulse_pin(2, 9);
        apply_reset();
        for (int p = 0; p < NUM_IO; p++) begin
            set_view(1'b1, p);
            check_led(led, exp_count[p][NUM_O-1:0], "count after mid-run reset");
        end
        // Pattern running, then reset under it
        @(negedge clk);
        btn[1] = 1'b1;
        wait_cycles(STEP_TB + 3);
        apply_reset();
        check_pins(ck_io[NUM_IO-1:0], NUM_IO'(1), "pattern after reset");
        wait_pattern_change(NUM_IO'(1), cur);
        check_pins(cur, NUM_IO'(2), "first step after reset");
    endtask

    initial begin
        void'($urandom(60));
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        sw       = '0;
        btn      = '0;
        pin_drv  = '0;
        apply_reset();
        test_reset_state();
        test_direct_view();
        test_edge_count();
        test_wrap_and_range();
        test_walking_one();
        test_reset_mid_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hdl/board_pkg.sv
hdl/gpio_pkg.sv
hdl/reset_sync.sv
hdl/pin_monitor.sv
hdl/led_view.sv
hdl/pattern_gen.sv
hdl/synthesis_optimization_top.sv
hdl/arty_a7_100.sv
dv/tb_arty_a7_100.sv
